// ==== verilog/osd_pkg.sv ====
package osd_pkg;

	// ************************************************************************
	// widths
	// ************************************************************************

	// one colour channel of the video path
	typedef logic [5:0] colour_t;

	// one byte of the osd bitmap, eight vertical pixels
	typedef logic [7:0] osd_byte_t;

	// bitmap address
	// [10:8] bitmap line, [7:0] column
	typedef logic [10:0] osd_addr_t;

	// pixel position inside the window
	typedef logic [7:0] osd_col_t;
	typedef logic [6:0] osd_row_t;

	// pixel or line counter of the incoming video
	typedef logic [9:0] vid_cnt_t;

	// first byte of a serial transfer
	typedef logic [7:0] spi_cmd_t;

	// ************************************************************************
	// window geometry
	// ************************************************************************

	localparam vid_cnt_t OSD_WIDTH = 10'd256;
	localparam vid_cnt_t OSD_HEIGHT = 10'd128;

	// shift away from the picture centre
	localparam vid_cnt_t OSD_X_OFFSET = 10'd0;
	localparam vid_cnt_t OSD_Y_OFFSET = 10'd0;

	// tint bits, red green blue from msb down
	localparam logic [2:0] OSD_COLOR = 3'b001;

	// ************************************************************************
	// command codes
	// ************************************************************************

	// 0100_xxxe, bit 0 is the new enable value
	localparam logic [3:0] CMD_ENABLE_MASK = 4'b0100;
	// 0010_0lll, bits 2..0 select the bitmap line
	localparam logic [4:0] CMD_WRITE_MASK = 5'b00100;

endpackage

// ==== verilog/osd_window_if.sv ====
`timescale 1ns/1ns

interface osd_window_if;
	import osd_pkg::*;

	// pixel inside the window columns, outside hsync
	logic h_active;
	// line inside the window rows, outside vsync
	logic v_active;
	// column inside the window, one ahead for the byte fetch
	osd_col_t col;
	// line inside the window
	osd_row_t row;

	// sync analyzer side
	modport analyzer (
		output h_active,
		output v_active,
		output col,
		output row
	);

	// mixer side
	modport mixer (
		input h_active,
		input v_active,
		input col,
		input row
	);

endinterface

// ==== verilog/osd_spi_rx.sv ====
`timescale 1ns/1ns

module osd_spi_rx (
	input logic clk_sys,
	input logic ss,
	input logic spi_sck,
	input logic spi_cs_n,
	input logic spi_sdi,
	output osd_pkg::osd_byte_t rx_byte,
	output logic rx_valid,
	output logic rx_first
);
	import osd_pkg::*;

	// two flop synchronizers for the serial lines
	logic [1:0] sck_sync;
	logic [1:0] cs_sync;
	logic [1:0] sdi_sync;
	// third sck stage for edge detection
	logic sck_prev;
	logic sck_rise;
	// bit position inside the current byte
	logic [2:0] bit_cnt;
	// next completed byte is the command byte
	logic first_pend;
	osd_byte_t shift_q;

	assign sck_rise = sck_sync[1] && !sck_prev;

	// ************************************************************************
	// control
	// ************************************************************************

	always_ff @(posedge clk_sys or posedge ss) begin
		if (ss) begin
			sck_sync <= 2'b00;
			// chip select idles deselected
			cs_sync <= 2'b11;
			sck_prev <= 1'b0;
			bit_cnt <= 3'd0;
			first_pend <= 1'b1;
			rx_valid <= 1'b0;
			rx_first <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[0], spi_sck};
			cs_sync <= {cs_sync[0], spi_cs_n};
			sck_prev <= sck_sync[1];
			rx_valid <= 1'b0;
			if (cs_sync[1]) begin
				// deselected, drop any partial byte
				bit_cnt <= 3'd0;
				first_pend <= 1'b1;
			end else if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					rx_valid <= 1'b1;
					rx_first <= first_pend;
					first_pend <= 1'b0;
				end
			end
		end
	end

	// ************************************************************************
	// data path, msb first
	// ************************************************************************

	always_ff @(posedge clk_sys) begin
		sdi_sync <= {sdi_sync[0], spi_sdi};
		if (sck_rise && !cs_sync[1]) begin
			shift_q <= {shift_q[6:0], sdi_sync[1]};
			// last bit goes straight into the output byte
			if (bit_cnt == 3'd7)
				rx_byte <= {shift_q[6:0], sdi_sync[1]};
		end
	end

	// a byte needs eight sck periods, so strobes are never adjacent
	assert property (@(posedge clk_sys) disable iff (ss) rx_valid |=> !rx_valid);

endmodule

// ==== verilog/osd_cmd_store.sv ====
`timescale 1ns/1ns

module osd_cmd_store (
	input logic clk_sys,
	input logic ss,
	input logic ce_pix,
	input osd_pkg::osd_byte_t rx_byte,
	input logic rx_valid,
	input logic rx_first,
	input osd_pkg::osd_addr_t rd_addr,
	output osd_pkg::osd_byte_t rd_data,
	output logic osd_enable
);
	import osd_pkg::*;

	// the osd bitmap, 8 lines of 256 bytes
	osd_byte_t bitmap [2**$bits(osd_addr_t)];

	// command of the running transfer
	spi_cmd_t cmd_q;
	osd_addr_t wr_addr;

	// decode of the incoming byte when it is a command
	logic new_is_enable;
	logic new_is_write;
	// decode of the latched command for payload bytes
	logic cmd_is_write;
	logic wr_en;

	assign new_is_enable = (rx_byte[7:4] == CMD_ENABLE_MASK);
	assign new_is_write = (rx_byte[7:3] == CMD_WRITE_MASK);
	assign cmd_is_write = (cmd_q[7:3] == CMD_WRITE_MASK);

	// payload byte of a write transfer
	assign wr_en = rx_valid && !rx_first && cmd_is_write;

	// ************************************************************************
	// command decode
	// ************************************************************************

	always_ff @(posedge clk_sys or posedge ss) begin
		if (ss) begin
			cmd_q <= '0;
			wr_addr <= '0;
			osd_enable <= 1'b0;
		end else if (rx_valid) begin
			if (rx_first) begin
				cmd_q <= rx_byte;
				// enable or disable, value in bit 0
				if (new_is_enable)
					osd_enable <= rx_byte[0];
				// line write starts at column 0 of the selected line
				if (new_is_write)
					wr_addr <= {rx_byte[2:0], 8'h00};
			end else if (cmd_is_write) begin
				// wraps at 2048 into line 0
				wr_addr <= wr_addr + 11'd1;
			end
		end
	end

	// ************************************************************************
	// bitmap memory
	// ************************************************************************

	// one write port from the serial side
	always_ff @(posedge clk_sys) begin
		if (wr_en)
			bitmap[wr_addr] <= rx_byte;
	end

	// one registered read port, advanced with the pixel clock enable
	always_ff @(posedge clk_sys) begin
		if (ce_pix)
			rd_data <= bitmap[rd_addr];
	end

	// payload of any non write command must leave the write pointer alone
	assert property (@(posedge clk_sys) disable iff (ss)
		rx_valid && !rx_first && !cmd_is_write |=> $stable(wr_addr));

endmodule

// ==== verilog/osd_sync_analyzer.sv ====
`timescale 1ns/1ns

module osd_sync_analyzer (
	input logic clk_sys,
	input logic ss,
	input logic ce_pix,
	input logic hs_in,
	input logic vs_in,
	osd_window_if.analyzer win
);
	import osd_pkg::*;

	// horizontal measurement
	logic hs_d1;
	logic hs_d2;
	vid_cnt_t h_cnt;
	vid_cnt_t hs_high;
	vid_cnt_t hs_low;
	logic hs_pol;
	vid_cnt_t h_width;
	vid_cnt_t h_start;
	vid_cnt_t h_end;
	vid_cnt_t h_col;
	logic h_win;

	// vertical measurement
	logic hs_prev;
	logic line_tick;
	logic vs_d1;
	logic vs_d2;
	vid_cnt_t v_cnt;
	vid_cnt_t vs_high;
	vid_cnt_t vs_low;
	logic vs_pol;
	vid_cnt_t v_width;
	vid_cnt_t v_start;
	vid_cnt_t v_end;
	vid_cnt_t v_row;
	logic v_win;

	// all four phase lengths seen at least once
	logic meas_valid;

	// ************************************************************************
	// horizontal, counted in pixels
	// ************************************************************************

	// sync is the shorter phase, the visible part the longer one
	assign hs_pol = hs_high < hs_low;
	assign h_width = hs_pol ? hs_low : hs_high;
	// centred window, counted from the end of hsync
	assign h_start = (h_width >> 1) + OSD_X_OFFSET - (OSD_WIDTH >> 1);
	// flag is registered, open for counts h_start+1 up to h_end
	assign h_end = h_start + OSD_WIDTH;

	always_ff @(posedge clk_sys or posedge ss) begin
		if (ss) begin
			hs_d1 <= 1'b0;
			hs_d2 <= 1'b0;
			h_cnt <= '0;
			hs_high <= '0;
			hs_low <= '0;
		end else if (ce_pix) begin
			hs_d1 <= hs_in;
			hs_d2 <= hs_d1;
			// counter sits one below the phase length at the closing edge
			if (hs_d2 && !hs_d1) begin
				// falling edge closes a high phase
				h_cnt <= '0;
				hs_high <= h_cnt + 10'd1;
			end else if (!hs_d2 && hs_d1) begin
				// rising edge closes a low phase
				h_cnt <= '0;
				hs_low <= h_cnt + 10'd1;
			end else begin
				h_cnt <= h_cnt + 10'd1;
			end
		end
	end

	// ************************************************************************
	// vertical, counted in lines
	// ************************************************************************

	assign vs_pol = vs_high < vs_low;
	assign v_width = vs_pol ? vs_low : vs_high;
	assign v_start = (v_width >> 1) + OSD_Y_OFFSET - (OSD_HEIGHT >> 1);
	assign v_end = v_start + OSD_HEIGHT;

	// one tick per rising edge of hsync
	assign line_tick = hs_in && !hs_prev;

	always_ff @(posedge clk_sys or posedge ss) begin
		if (ss) begin
			hs_prev <= 1'b0;
			vs_d1 <= 1'b0;
			vs_d2 <= 1'b0;
			v_cnt <= '0;
			vs_high <= '0;
			vs_low <= '0;
		end else begin
			hs_prev <= hs_in;
			if (line_tick) begin
				vs_d1 <= vs_in;
				vs_d2 <= vs_d1;
				if (vs_d2 && !vs_d1) begin
					v_cnt <= '0;
					vs_high <= v_cnt + 10'd1;
				end else if (!vs_d2 && vs_d1) begin
					v_cnt <= '0;
					vs_low <= v_cnt + 10'd1;
				end else begin
					v_cnt <= v_cnt + 10'd1;
				end
			end
		end
	end

	// ************************************************************************
	// window flags
	// ************************************************************************

	assign meas_valid = (hs_high != '0) && (hs_low != '0) && (vs_high != '0) && (vs_low != '0);

	always_ff @(posedge clk_sys or posedge ss) begin
		if (ss) begin
			h_win <= 1'b0;
			v_win <= 1'b0;
		end else begin
			// sync level always closes the window
			if (hs_in == hs_pol)
				h_win <= 1'b0;
			else if (meas_valid && h_cnt == h_start)
				h_win <= 1'b1;
			else if (h_cnt == h_end)
				h_win <= 1'b0;
			if (vs_in == vs_pol)
				v_win <= 1'b0;
			else if (meas_valid && v_cnt == v_start)
				v_win <= 1'b1;
			else if (v_cnt == v_end)
				v_win <= 1'b0;
		end
	end

	// flag lags the counter by one
	// so this column runs one pixel ahead for the registered byte read
	assign h_col = h_cnt - h_start;
	assign v_row = v_cnt - v_start;

	assign win.h_active = h_win;
	assign win.v_active = v_win;
	assign win.col = h_col[7:0];
	assign win.row = v_row[6:0];

	// window must have closed before the sync pulse starts
	assert property (@(posedge clk_sys) disable iff (ss)
		(hs_in == hs_pol) |-> !win.h_active);

endmodule

// ==== verilog/osd_mixer.sv ====
`timescale 1ns/1ns

module osd_mixer (
	input logic ce_pix,
	input osd_pkg::colour_t red_in,
	input osd_pkg::colour_t green_in,
	input osd_pkg::colour_t blue_in,
	input osd_pkg::osd_byte_t rd_data,
	input logic osd_enable,
	osd_window_if.mixer win,
	output osd_pkg::osd_addr_t rd_addr,
	output osd_pkg::colour_t red_out,
	output osd_pkg::colour_t green_out,
	output osd_pkg::colour_t blue_out
);
	import osd_pkg::*;

	// overlay drawn on this pixel
	logic osd_de;
	// bitmap bit for this pixel
	logic osd_pixel;
	osd_addr_t fetch_addr;

	// blended channel
	// pixel bit twice, tint bit, then the dimmed input
	function automatic colour_t blend(colour_t chan, logic pix, logic tint);
		blend = {pix, pix, tint, chan[5:3]};
	endfunction

	// ************************************************************************
	// bitmap fetch
	// ************************************************************************

	// each byte covers 16 lines, rows 6..4 pick the bitmap line
	assign fetch_addr = {win.row[6:4], win.col};

	// the store samples the address only on pixel enable
	// park it otherwise so the read port stays quiet
	assign rd_addr = ce_pix ? fetch_addr : '0;

	// one bit per two lines
	assign osd_pixel = rd_data[win.row[3:1]];

	// ************************************************************************
	// colour mix
	// ************************************************************************

	assign osd_de = osd_enable && win.h_active && win.v_active;

	// outside the window the input passes unchanged
	assign red_out = osd_de ? blend(red_in, osd_pixel, OSD_COLOR[2]) : red_in;
	assign green_out = osd_de ? blend(green_in, osd_pixel, OSD_COLOR[1]) : green_in;
	assign blue_out = osd_de ? blend(blue_in, osd_pixel, OSD_COLOR[0]) : blue_in;

endmodule

// ==== verilog/osd_top.sv ====
`timescale 1ns/1ns

module osd_top (
	input logic clk_sys,
	input logic ss,
	input logic ce_pix,
	// serial command link from the io controller
	input logic spi_sck,
	input logic spi_cs_n,
	input logic spi_sdi,
	// video from the core
	input osd_pkg::colour_t red_in,
	input osd_pkg::colour_t green_in,
	input osd_pkg::colour_t blue_in,
	input logic hs_in,
	input logic vs_in,
	// video to the connector
	output osd_pkg::colour_t red_out,
	output osd_pkg::colour_t green_out,
	output osd_pkg::colour_t blue_out,
	output logic hs_out,
	output logic vs_out
);
	import osd_pkg::*;

	// serial receiver to command store
	osd_byte_t rx_byte;
	logic rx_valid;
	logic rx_first;

	// command store to mixer
	osd_addr_t rd_addr;
	osd_byte_t rd_data;
	logic osd_enable;

	// window position from the analyzer
	osd_window_if win_if ();

	// ************************************************************************
	// command path
	// ************************************************************************

	osd_spi_rx spi_rx_i (
		.clk_sys(clk_sys),
		.ss(ss),
		.spi_sck(spi_sck),
		.spi_cs_n(spi_cs_n),
		.spi_sdi(spi_sdi),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.rx_first(rx_first)
	);

	osd_cmd_store cmd_store_i (
		.clk_sys(clk_sys),
		.ss(ss),
		.ce_pix(ce_pix),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.rx_first(rx_first),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.osd_enable(osd_enable)
	);

	// ************************************************************************
	// timing path and mix
	// ************************************************************************

	osd_sync_analyzer sync_analyzer_i (
		.clk_sys(clk_sys),
		.ss(ss),
		.ce_pix(ce_pix),
		.hs_in(hs_in),
		.vs_in(vs_in),
		.win(win_if.analyzer)
	);

	osd_mixer mixer_i (
		.ce_pix(ce_pix),
		.red_in(red_in),
		.green_in(green_in),
		.blue_in(blue_in),
		.rd_data(rd_data),
		.osd_enable(osd_enable),
		.win(win_if.mixer),
		.rd_addr(rd_addr),
		.red_out(red_out),
		.green_out(green_out),
		.blue_out(blue_out)
	);

	// syncs go straight through, no added delay
	assign hs_out = hs_in;
	assign vs_out = vs_in;

endmodule

// ==== sim/tb_osd.sv ====
`timescale 1ns/1ns

module tb_osd;
	import osd_pkg::*;

	// small test frame
	localparam int H_TOTAL = 400;
	localparam int H_SYNC = 40;
	localparam int V_TOTAL = 300;
	localparam int V_SYNC = 4;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

	logic clk_sys;
	logic ss;
	logic ce_pix;
	logic spi_sck;
	logic spi_cs_n;
	logic spi_sdi;
	colour_t red_in;
	colour_t green_in;
	colour_t blue_in;
	logic hs_in;
	logic vs_in;
	colour_t red_out;
	colour_t green_out;
	colour_t blue_out;
	logic hs_out;
	logic vs_out;

	// reference model state
	osd_byte_t model_mem [2048];
	logic model_en;
	// first window pixel and line as the dut sees them
	int px0;
	int ly0;

	// video generator state
	integer seed;
	int frame_no;
	logic sync_pos;
	logic check_on;

	// bytes of the next serial transfer
	osd_byte_t tx_q [$];

	// bookkeeping
	string cur_test;
	int test_err;
	int err_total;
	int check_total;
	int test_total;

	osd_top dut_i (
		.clk_sys(clk_sys),
		.ss(ss),
		.ce_pix(ce_pix),
		.spi_sck(spi_sck),
		.spi_cs_n(spi_cs_n),
		.spi_sdi(spi_sdi),
		.red_in(red_in),
		.green_in(green_in),
		.blue_in(blue_in),
		.hs_in(hs_in),
		.vs_in(vs_in),
		.red_out(red_out),
		.green_out(green_out),
		.blue_out(blue_out),
		.hs_out(hs_out),
		.vs_out(vs_out)
	);

	always #10 clk_sys = !clk_sys;

	// ************************************************************************
	// checks
	// ************************************************************************

	task automatic check_colour(string what, colour_t exp, colour_t act);
		check_total++;
		if (exp !== act) begin
			err_total++;
			test_err++;
			// only the first few per test, the count still grows
			if (test_err <= 8)
				$display("FAIL %s %s expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_bit(string what, logic exp, logic act);
		check_total++;
		if (exp !== act) begin
			err_total++;
			test_err++;
			if (test_err <= 8)
				$display("FAIL %s %s expected %b actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic start_test(string name);
		cur_test = name;
		test_err = 0;
		test_total++;
	endtask

	task automatic finish_test;
		if (test_err == 0)
			$display("test %s: ok", cur_test);
		else
			$display("test %s: %0d mismatches", cur_test, test_err);
	endtask

	task automatic stop_on_timeout(string what);
		$display("ERROR: timed out waiting for %s", what);
		$display("TB FAILED");
		$finish;
	endtask

	// ************************************************************************
	// reference model
	// ************************************************************************

	// first pixel or line of the window
	// lag covers the dut pipeline
	function automatic int window_first(int total, int sync, int size, int offset, int lag);
		int vis;
		int start;
		vis = total - sync;
		start = vis / 2 + offset - size / 2;
		return sync + lag + start;
	endfunction

	// decode the queued bytes as one complete transfer
	task automatic apply_transfer;
		osd_byte_t cmd;
		int addr;
		logic is_write;
		cmd = tx_q[0];
		is_write = (cmd[7:3] == CMD_WRITE_MASK);
		addr = cmd[2:0] * 256;
		if (cmd[7:4] == CMD_ENABLE_MASK)
			model_en = cmd[0];
		for (int i = 1; i < tx_q.size(); i++) begin
			if (is_write) begin
				model_mem[addr] = tx_q[i];
				addr = (addr + 1) % 2048;
			end
		end
	endtask

	task automatic compare_pixel(int l, int p);
		colour_t er;
		colour_t eg;
		colour_t eb;
		logic on;
		logic pix;
		int x;
		int row;
		int addr;
		on = model_en && l >= ly0 && l < ly0 + OSD_HEIGHT
			&& p >= px0 && p < px0 + OSD_WIDTH;
		er = red_in;
		eg = green_in;
		eb = blue_in;
		if (on) begin
			// window column and row, bit per two lines
			x = p - px0;
			row = l - ly0;
			addr = (row / 16) * 256 + x;
			pix = model_mem[addr][(row % 16) / 2];
			er = {pix, pix, OSD_COLOR[2], red_in[5:3]};
			eg = {pix, pix, OSD_COLOR[1], green_in[5:3]};
			eb = {pix, pix, OSD_COLOR[0], blue_in[5:3]};
		end
		check_colour("red", er, red_out);
		check_colour("green", eg, green_out);
		check_colour("blue", eb, blue_out);
		check_bit("hs_out", hs_in, hs_out);
		check_bit("vs_out", vs_in, vs_out);
	endtask

	// ************************************************************************
	// drivers
	// ************************************************************************

	task automatic tick(int n);
		repeat (n) @(posedge clk_sys);
		#2;
	endtask

	// endless frames, polarity taken at each frame start
	task automatic run_video;
		logic gen_pos;
		logic hsync;
		logic vsync;
		logic [31:0] rnd;
		forever begin
			for (int l = 0; l < V_TOTAL; l++) begin
				for (int p = 0; p < H_TOTAL; p++) begin
					@(posedge clk_sys);
					#2;
					if (l == 0 && p == 0) begin
						frame_no++;
						gen_pos = sync_pos;
					end
					hsync = (p < H_SYNC);
					vsync = (l < V_SYNC);
					hs_in = gen_pos ? hsync : !hsync;
					vs_in = gen_pos ? vsync : !vsync;
					rnd = $random(seed);
					red_in = rnd[5:0];
					green_in = rnd[13:8];
					blue_in = rnd[21:16];
					// mid pixel, everything settled
					#10;
					if (check_on)
						compare_pixel(l, p);
				end
			end
		end
	endtask

	task automatic shift_bits(osd_byte_t b, int n);
		for (int i = 0; i < n; i++) begin
			spi_sdi = b[7 - i];
			spi_sck = 1'b0;
			tick(5);
			spi_sck = 1'b1;
			tick(5);
		end
	endtask

	// cut_bits above zero ends the transfer inside an extra byte
	task automatic send_transfer(int cut_bits);
		spi_cs_n = 1'b0;
		tick(5);
		foreach (tx_q[i])
			shift_bits(tx_q[i], 8);
		if (cut_bits > 0)
			shift_bits(8'ha5, cut_bits);
		spi_sck = 1'b0;
		tick(5);
		spi_cs_n = 1'b1;
		tick(12);
	endtask

	task automatic wait_frames(int n);
		int target;
		int cnt;
		target = frame_no + n;
		cnt = 0;
		while (frame_no < target) begin
			@(posedge clk_sys);
			cnt++;
			if (cnt > (n + 1) * FRAME_CYCLES)
				stop_on_timeout("frame start");
		end
	endtask

	// compare whole frames from the next frame start
	task automatic check_frames(int n);
		wait_frames(1);
		check_on = 1'b1;
		wait_frames(n);
		check_on = 1'b0;
	endtask

	task automatic command(osd_byte_t cmd);
		tx_q = {cmd};
		send_transfer(0);
		apply_transfer();
	endtask

	// ************************************************************************
	// tests
	// ************************************************************************

	initial begin
		clk_sys = 1'b0;
		ss = 1'b1;
		ce_pix = 1'b1;
		spi_sck = 1'b0;
		spi_cs_n = 1'b1;
		spi_sdi = 1'b0;
		red_in = '0;
		green_in = '0;
		blue_in = '0;
		hs_in = 1'b0;
		vs_in = 1'b0;
		seed = 32'h6e63;
		frame_no = 0;
		sync_pos = 1'b1;
		check_on = 1'b0;
		model_en = 1'b0;
		err_total = 0;
		check_total = 0;
		test_total = 0;
		px0 = window_first(H_TOTAL, H_SYNC, OSD_WIDTH, OSD_X_OFFSET, 3);
		ly0 = window_first(V_TOTAL, V_SYNC, OSD_HEIGHT, OSD_Y_OFFSET, 1);
		tick(4);
		ss = 1'b0;
		fork
			run_video();
		join_none

		start_test("pass_through");
		check_frames(2);
		finish_test();

		start_test("full_bitmap");
		for (int ln = 0; ln < 8; ln++) begin
			tx_q = {osd_byte_t'(8'h20 | ln)};
			for (int c = 0; c < 256; c++)
				tx_q.push_back(osd_byte_t'((c * 7 + ln * 29) ^ (c >> 2)));
			send_transfer(0);
			apply_transfer();
		end
		check_frames(1);
		command(8'h41);
		check_frames(1);
		finish_test();

		// 300 payload bytes run from line 2 into line 3
		start_test("auto_increment");
		tx_q = {8'h22};
		for (int c = 0; c < 300; c++)
			tx_q.push_back(osd_byte_t'(c * 3 + 8'h5a));
		send_transfer(0);
		apply_transfer();
		check_frames(1);
		finish_test();

		start_test("bad_command_and_disable");
		tx_q = {8'h80, 8'hff, 8'h00, 8'h55};
		send_transfer(0);
		apply_transfer();
		check_frames(1);
		command(8'h40);
		check_frames(1);
		finish_test();

		// analyzer settles on the new polarity over two frames
		start_test("inverted_sync");
		command(8'h41);
		sync_pos = 1'b0;
		wait_frames(3);
		check_frames(1);
		finish_test();

		start_test("cut_transfer");
		tx_q = {8'h25, 8'hc3, 8'h3c};
		send_transfer(3);
		apply_transfer();
		tx_q = {8'h26};
		for (int c = 0; c < 10; c++)
			tx_q.push_back(osd_byte_t'(8'hf0 ^ c));
		send_transfer(0);
		apply_transfer();
		check_frames(1);
		finish_test();

		$display("tests %0d, checks %0d, errors %0d", test_total, check_total, err_total);
		if (err_total == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
verilog/osd_pkg.sv
verilog/osd_window_if.sv
verilog/osd_spi_rx.sv
verilog/osd_cmd_store.sv
verilog/osd_sync_analyzer.sv
verilog/osd_mixer.sv
verilog/osd_top.sv
sim/tb_osd.sv
